// File: hdl/ApLine.sv
`timescale 1ns/1ps
`include "dekatron_defines.svh"

module ApLine (
    input  logic                  Clk,
    input  logic                  Rst_n,
    input  logic                  Tick,
    input  logic                  ApRequest,
    input  logic                  DataRequest,
    input  logic                  Dec,
    output logic                  Ready,
    output logic                  DataZero,
    output DekatronPkg::apAddr_t  Address,
    output DekatronPkg::data_t    Data
);

    typedef enum logic [1:0] {AIdle, ALoad, AWrite} apState_e;

    apState_e            apState;
    DekatronPkg::data_t  cells [`DATA_DEPTH];
    int                  cellIdx;
    logic                apStep;
    logic                dataStep;
    logic                wrEn;

    assign cellIdx  = DekatronPkg::bcdToIndex(32'(Address), `AP_DIGITS);
    assign apStep   = (apState == AIdle) && ApRequest;
    assign dataStep = (apState == AIdle) && DataRequest;
    // Old cell saved before a pointer move, stepped value saved in AWrite
    assign wrEn     = Tick && (apStep || apState == AWrite);

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < `DATA_DEPTH; i++) begin
                cells[i] <= '0;
            end
        end else if (wrEn) begin
            cells[cellIdx] <= Data;
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            apState <= AIdle;
            Ready   <= 1'b0;
        end else if (Tick) begin
            Ready <= 1'b0;
            case (apState)
                AIdle: begin
                    if (DataRequest) begin
                        apState <= AWrite;
                    end else if (ApRequest) begin
                        apState <= ALoad;
                    end
                end
                ALoad:   apState <= AWrite;  // Counter picks up the new cell
                AWrite: begin
                    Ready   <= 1'b1;
                    apState <= AIdle;
                end
                default: apState <= AIdle;
            endcase
        end
    end

    DekatronCounter #(.DIGITS(`AP_DIGITS)) apCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick),
        .Inc(apStep && !Dec), .Dec(apStep && Dec), .Load(1'b0), .LoadValue('0),
        .Value(Address), .Zero()
    );

    DekatronCounter #(.DIGITS(`DATA_DIGITS)) dataCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick),
        .Inc(dataStep && !Dec), .Dec(dataStep && Dec),
        .Load(apState == ALoad), .LoadValue(cells[cellIdx]),
        .Value(Data), .Zero(DataZero)
    );

    assert property (@(posedge Clk) disable iff (!Rst_n) !(ApRequest && DataRequest))
        else $error("Pointer and data request together");

endmodule

// File: hdl/ClockDivider.sv
`timescale 1ns/1ps
`include "dekatron_defines.svh"

module ClockDivider (
    input  logic Clk,
    input  logic Rst_n,
    output logic Tick
);

    localparam int CntW = $clog2(`CLK_DIV + 1);

    logic [CntW-1:0] cycleCnt;
    logic            lastCycle;

    assign lastCycle = (cycleCnt == CntW'(`CLK_DIV - 1));

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            cycleCnt <= '0;
            Tick     <= 1'b0;
        end else begin
            Tick <= lastCycle;  // First pulse CLK_DIV cycles out of reset
            if (lastCycle) begin
                cycleCnt <= '0;
            end else begin
                cycleCnt <= cycleCnt + 1'b1;
            end
        end
    end

    assert property (@(posedge Clk) disable iff (!Rst_n) Tick |=> !Tick)
        else $error("Tick high on consecutive cycles");

endmodule

// File: hdl/DekatronCounter.sv
`timescale 1ns/1ps
`include "dekatron_defines.svh"

module DekatronCounter #(
    parameter int DIGITS = 1
) (
    input  logic                                Clk,
    input  logic                                Rst_n,
    input  logic                                Tick,
    input  logic                                Inc,
    input  logic                                Dec,
    input  logic                                Load,
    input  logic [DIGITS*`DEKATRON_WIDTH-1:0]   LoadValue,
    output logic [DIGITS*`DEKATRON_WIDTH-1:0]   Value,
    output logic                                Zero
);

    localparam int W = `DEKATRON_WIDTH;

    logic [DIGITS*W-1:0] nextUp;
    logic [DIGITS*W-1:0] nextDown;

    // Ripple carry and borrow through the decades
    always_comb begin
        logic         carry;
        logic         borrow;
        logic [W-1:0] digit;
        carry    = 1'b1;
        borrow   = 1'b1;
        nextUp   = Value;
        nextDown = Value;
        for (int i = 0; i < DIGITS; i++) begin
            digit = Value[i*W +: W];
            if (carry) begin
                if (digit == W'(9)) begin
                    nextUp[i*W +: W] = '0;
                end else begin
                    nextUp[i*W +: W] = digit + 1'b1;
                    carry = 1'b0;
                end
            end
            if (borrow) begin
                if (digit == '0) begin
                    nextDown[i*W +: W] = W'(9);  // Wrap to nine, keep borrowing
                end else begin
                    nextDown[i*W +: W] = digit - 1'b1;
                    borrow = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            Value <= '0;
        end else if (Tick) begin
            if (Load) begin
                Value <= LoadValue;
            end else if (Inc) begin
                Value <= nextUp;
            end else if (Dec) begin
                Value <= nextDown;
            end
        end
    end

    assign Zero = (Value == '0);

    assert property (@(posedge Clk) disable iff (!Rst_n) !(Inc && Dec))
        else $error("Counter stepped up and down together");

    for (genvar g = 0; g < DIGITS; g++) begin : gDigitCheck
        assert property (@(posedge Clk) disable iff (!Rst_n) Value[g*W +: W] <= W'(9))
            else $error("Decade %0d left BCD range", g);
    end

endmodule

// File: hdl/DekatronPC.sv
`timescale 1ns/1ps

module DekatronPC (
    input  logic                    Clk,
    input  logic                    Rst_n,
    input  logic                    Halt,
    input  logic                    Step,
    input  logic                    Run,
    input  logic                    ProgWe,
    input  DekatronPkg::ipAddr_t    ProgAddr,
    input  DekatronPkg::insn_t      ProgData,
    output DekatronPkg::ipAddr_t    IpAddress,
    output DekatronPkg::apAddr_t    ApAddress,
    output DekatronPkg::data_t      Data,
    output DekatronPkg::loopCnt_t   LoopCount,
    output DekatronPkg::cpuState_e  CurrentState,
    output logic                    CoutValid
);

    logic                Tick;
    logic                IpRequest;
    logic                IpReady;
    logic                DataRequest;
    logic                ApRequest;
    logic                ApReady;
    logic                DataZero;
    logic                apDec;
    DekatronPkg::insn_t  Insn;
    logic                stepPending;
    logic                runPending;
    logic                isHalt;
    logic                isDataOp;
    logic                isApOp;
    logic                isCout;
    logic                haltDone;
    logic                insnDone;

    assign isHalt   = (Insn == DekatronPkg::insn_t'(DekatronPkg::OpHalt));
    assign isCout   = (Insn == DekatronPkg::insn_t'(DekatronPkg::OpCout));
    assign isDataOp = (Insn == DekatronPkg::insn_t'(DekatronPkg::OpDataInc)) ||
                      (Insn == DekatronPkg::insn_t'(DekatronPkg::OpDataDec));
    assign isApOp   = (Insn == DekatronPkg::insn_t'(DekatronPkg::OpApInc)) ||
                      (Insn == DekatronPkg::insn_t'(DekatronPkg::OpApDec));

    assign haltDone = (CurrentState == DekatronPkg::StFetch) && IpReady && isHalt;
    // NOP, COUT and unknown codes finish in fetch
    assign insnDone = ((CurrentState == DekatronPkg::StFetch) && IpReady &&
                       !isHalt && !isDataOp && !isApOp) ||
                      ((CurrentState == DekatronPkg::StExec) && ApReady);

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            CurrentState <= DekatronPkg::StHalt;
            IpRequest    <= 1'b0;
            DataRequest  <= 1'b0;
            ApRequest    <= 1'b0;
            apDec        <= 1'b0;
        end else if (Tick) begin
            IpRequest   <= 1'b0;
            DataRequest <= 1'b0;
            ApRequest   <= 1'b0;
            case (CurrentState)
                DekatronPkg::StHalt: begin
                    if (runPending || stepPending) begin
                        CurrentState <= DekatronPkg::StIdle;
                    end
                end
                DekatronPkg::StIdle: begin
                    CurrentState <= DekatronPkg::StFetch;
                    IpRequest    <= 1'b1;
                end
                DekatronPkg::StFetch: begin
                    if (haltDone) begin
                        CurrentState <= DekatronPkg::StHalt;
                    end else if (IpReady && (isDataOp || isApOp)) begin
                        CurrentState <= DekatronPkg::StExec;
                        DataRequest  <= isDataOp;
                        ApRequest    <= isApOp;
                        apDec        <= Insn[0];  // Odd codes step down
                    end
                end
                default: ;  // StExec waits for the AP line
            endcase
            if (insnDone) begin
                if (Halt || stepPending) begin
                    CurrentState <= DekatronPkg::StHalt;
                end else begin
                    CurrentState <= DekatronPkg::StFetch;
                    IpRequest    <= 1'b1;
                end
            end
        end
    end

    // Step and Run pulses may be shorter than a Tick
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            stepPending <= 1'b0;
            runPending  <= 1'b0;
            CoutValid   <= 1'b0;
        end else begin
            if (Step) begin
                stepPending <= 1'b1;
            end else if (Tick && (insnDone || haltDone)) begin
                stepPending <= 1'b0;
            end
            if (Run && CurrentState == DekatronPkg::StHalt) begin
                runPending <= 1'b1;
            end else if (Tick) begin
                runPending <= 1'b0;
            end
            CoutValid <= Tick && (CurrentState == DekatronPkg::StFetch) && IpReady && isCout;
        end
    end

    ClockDivider clockDivider (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick)
    );

    IpLine ipLine (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick),
        .Request(IpRequest), .DataZero(DataZero),
        .ProgWe(ProgWe && CurrentState == DekatronPkg::StHalt),
        .ProgAddr(ProgAddr), .ProgData(ProgData),
        .Ready(IpReady), .Insn(Insn), .Address(IpAddress), .LoopCount(LoopCount)
    );

    ApLine apLine (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick),
        .ApRequest(ApRequest), .DataRequest(DataRequest), .Dec(apDec),
        .Ready(ApReady), .DataZero(DataZero), .Address(ApAddress), .Data(Data)
    );

endmodule

// File: hdl/DekatronPkg.sv
`include "dekatron_defines.svh"

package DekatronPkg;

    typedef logic [`IP_DIGITS*`DEKATRON_WIDTH-1:0]   ipAddr_t;
    typedef logic [`AP_DIGITS*`DEKATRON_WIDTH-1:0]   apAddr_t;
    typedef logic [`DATA_DIGITS*`DEKATRON_WIDTH-1:0] data_t;
    typedef logic [`LOOP_DIGITS*`DEKATRON_WIDTH-1:0] loopCnt_t;
    typedef logic [`INSN_WIDTH-1:0]                  insn_t;

    typedef enum logic [`INSN_WIDTH-1:0] {
        OpNop       = 0,
        OpHalt      = 1,
        OpDataInc   = 2,
        OpDataDec   = 3,
        OpApInc     = 4,
        OpApDec     = 5,
        OpCout      = 8,
        OpLoopOpen  = 10,
        OpLoopClose = 11
    } opcode_e;

    typedef enum logic [1:0] {
        StHalt  = 2'd0,
        StIdle  = 2'd1,
        StFetch = 2'd2,
        StExec  = 2'd3
    } cpuState_e;

    // BCD digit chain to a plain array index
    function automatic int bcdToIndex(input logic [31:0] bcd, input int digits);
        int idx;
        idx = 0;
        for (int i = digits - 1; i >= 0; i--) begin
            idx = idx * 10 + int'(bcd[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH]);
        end
        return idx;
    endfunction

endpackage

// File: hdl/IpLine.sv
`timescale 1ns/1ps
`include "dekatron_defines.svh"

module IpLine (
    input  logic                   Clk,
    input  logic                   Rst_n,
    input  logic                   Tick,
    input  logic                   Request,
    input  logic                   DataZero,
    input  logic                   ProgWe,
    input  DekatronPkg::ipAddr_t   ProgAddr,
    input  DekatronPkg::insn_t     ProgData,
    output logic                   Ready,
    output DekatronPkg::insn_t     Insn,
    output DekatronPkg::ipAddr_t   Address,
    output DekatronPkg::loopCnt_t  LoopCount
);

    typedef enum logic [1:0] {SIdle, SRead, SScanFwd, SScanBwd} scanState_e;

    scanState_e          scanState;
    DekatronPkg::insn_t  prog [`PROG_DEPTH];
    DekatronPkg::insn_t  word;
    logic                isOpen;
    logic                isClose;
    logic                lastBracket;
    logic                ptrInc;
    logic                ptrDec;
    logic                loopInc;
    logic                loopDec;

    always_ff @(posedge Clk) begin
        if (ProgWe) begin
            prog[DekatronPkg::bcdToIndex(32'(ProgAddr), `IP_DIGITS)] <= ProgData;
        end
    end

    assign word        = prog[DekatronPkg::bcdToIndex(32'(Address), `IP_DIGITS)];
    assign isOpen      = (word == DekatronPkg::insn_t'(DekatronPkg::OpLoopOpen));
    assign isClose     = (word == DekatronPkg::insn_t'(DekatronPkg::OpLoopClose));
    assign lastBracket = (LoopCount == DekatronPkg::loopCnt_t'(1));  // Outermost level

    always_comb begin
        ptrInc  = 1'b0;
        ptrDec  = 1'b0;
        loopInc = 1'b0;
        loopDec = 1'b0;
        case (scanState)
            SRead: begin
                if (isClose && !DataZero) begin
                    ptrDec  = 1'b1;  // Back over the close
                    loopInc = 1'b1;
                end else begin
                    ptrInc  = 1'b1;
                    loopInc = isOpen && DataZero;
                end
            end
            SScanFwd: begin
                ptrInc  = 1'b1;
                loopInc = isOpen;
                loopDec = isClose;
            end
            SScanBwd: begin
                loopInc = isClose;
                loopDec = isOpen;
                ptrInc  = isOpen && lastBracket;  // Land just after the matching open
                ptrDec  = !(isOpen && lastBracket);
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            scanState <= SIdle;
            Ready     <= 1'b0;
        end else if (Tick) begin
            Ready <= 1'b0;
            case (scanState)
                SIdle: begin
                    if (Request) begin
                        scanState <= SRead;
                    end
                end
                SRead: begin
                    if (isClose && !DataZero) begin
                        scanState <= SScanBwd;
                    end else if (isOpen && DataZero) begin
                        scanState <= SScanFwd;
                    end else if (!isOpen && !isClose) begin
                        Ready     <= 1'b1;
                        scanState <= SIdle;
                    end
                end
                SScanFwd: begin
                    if (isClose && lastBracket) begin
                        scanState <= SRead;
                    end
                end
                SScanBwd: begin
                    if (isOpen && lastBracket) begin
                        scanState <= SRead;
                    end
                end
                default: scanState <= SIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (Tick && scanState == SRead && !isOpen && !isClose) begin
            Insn <= word;
        end
    end

    DekatronCounter #(.DIGITS(`IP_DIGITS)) ipCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick),
        .Inc(ptrInc), .Dec(ptrDec), .Load(1'b0), .LoadValue('0),
        .Value(Address), .Zero()
    );

    DekatronCounter #(.DIGITS(`LOOP_DIGITS)) loopCounter (
        .Clk(Clk), .Rst_n(Rst_n), .Tick(Tick),
        .Inc(loopInc), .Dec(loopDec), .Load(1'b0), .LoadValue('0),
        .Value(LoopCount), .Zero()
    );

    assert property (@(posedge Clk) disable iff (!Rst_n)
        (Tick && Request) |-> (scanState == SIdle))
        else $error("Fetch request while IP line busy");

endmodule

// File: hdl/dekatron_defines.svh
`ifndef DEKATRON_DEFINES_SVH
`define DEKATRON_DEFINES_SVH

// Bits per decade counter
`define DEKATRON_WIDTH 4

// Digits per counter chain
`define IP_DIGITS      2
`define AP_DIGITS      1
`define DATA_DIGITS    3
`define LOOP_DIGITS    1

// Store depths
`define PROG_DEPTH     100
`define DATA_DEPTH     10

// Clk cycles per Tick
`define CLK_DIV        4

`define INSN_WIDTH     4

`endif

// File: project.f
+incdir+hdl
hdl/DekatronPkg.sv
hdl/ClockDivider.sv
hdl/DekatronCounter.sv
hdl/IpLine.sv
hdl/ApLine.sv
hdl/DekatronPC.sv
testbench/DekatronPC_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for failures
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module DekatronPC_tb \
    -f project.f -o DekatronPC_tb \
    && ./obj_dir/DekatronPC_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation OK"; exit 0; }

// File: testbench/DekatronPC_tb.sv
`timescale 1ns/1ps
`include "dekatron_defines.svh"

module DekatronPC_tb;

    localparam logic [3:0] OpNop       = 4'd0;
    localparam logic [3:0] OpHalt      = 4'd1;
    localparam logic [3:0] OpDataInc   = 4'd2;
    localparam logic [3:0] OpDataDec   = 4'd3;
    localparam logic [3:0] OpApInc     = 4'd4;
    localparam logic [3:0] OpApDec     = 4'd5;
    localparam logic [3:0] OpCout      = 4'd8;
    localparam logic [3:0] OpLoopOpen  = 4'd10;
    localparam logic [3:0] OpLoopClose = 4'd11;

    localparam int StraightLen  = 60;
    localparam int LongLen      = 90;
    localparam int LoopLen      = 37;
    // Two straight-line runs, the loop program and two long runs
    localparam int TotalProgLen = 2 * StraightLen + LoopLen + 2 * LongLen;
    localparam int TimeoutLimit = TotalProgLen * 40 * `CLK_DIV;

    logic                    Clk;
    logic                    Rst_n;
    logic                    Halt;
    logic                    Step;
    logic                    Run;
    logic                    ProgWe;
    DekatronPkg::ipAddr_t    ProgAddr;
    DekatronPkg::insn_t      ProgData;
    DekatronPkg::ipAddr_t    IpAddress;
    DekatronPkg::apAddr_t    ApAddress;
    DekatronPkg::data_t      Data;
    DekatronPkg::loopCnt_t   LoopCount;
    DekatronPkg::cpuState_e  CurrentState;
    logic                    CoutValid;

    integer     seed;
    logic [3:0] progMem [100];
    int         mCells [10];  // Reference model state
    int         mAp;
    int         mIp;
    int         coutExp [$];
    int         traceIp [$];  // IP and AP after each instruction
    int         traceAp [$];
    int         coutTotal;
    int         coutSeen;
    int         coutErrors;
    bit         coutArmed;
    int         testErrors;
    int         testNum;
    int         passCount;
    int         failCount;
    int         cycleCount;
    int         loopN;
    int         haltDelay;
    int         resetDelay;

    DekatronPC uut (
        .Clk(Clk), .Rst_n(Rst_n), .Halt(Halt), .Step(Step), .Run(Run),
        .ProgWe(ProgWe), .ProgAddr(ProgAddr), .ProgData(ProgData),
        .IpAddress(IpAddress), .ApAddress(ApAddress), .Data(Data),
        .LoopCount(LoopCount), .CurrentState(CurrentState), .CoutValid(CoutValid)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    function automatic logic [31:0] toBcd(input int v);
        return {20'd0, 4'((v / 100) % 10), 4'((v / 10) % 10), 4'(v % 10)};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            testErrors++;
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("Test %0d %s: PASS", testNum, name);
        end else begin
            failCount++;
            $display("Test %0d %s: FAIL with %0d errors", testNum, name, testErrors);
        end
        testNum++;
        testErrors = 0;
    endtask

    task automatic applyReset();
        @(posedge Clk);
        Rst_n  <= 1'b0;
        Halt   <= 1'b0;
        Step   <= 1'b0;
        Run    <= 1'b0;
        ProgWe <= 1'b0;
        repeat (2) @(posedge Clk);
        Rst_n <= 1'b1;
        @(posedge Clk);
    endtask

    task automatic loadProgram(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge Clk);
            ProgWe   <= 1'b1;
            ProgAddr <= 8'(toBcd(i));
            ProgData <= progMem[i];
        end
        @(posedge Clk);
        ProgWe <= 1'b0;
    endtask

    task automatic pulseRun();
        @(posedge Clk);
        Run <= 1'b1;
        @(posedge Clk);
        Run <= 1'b0;
    endtask

    task automatic pulseStep();
        @(posedge Clk);
        Step <= 1'b1;
        @(posedge Clk);
        Step <= 1'b0;
    endtask

    // Leave StHalt, then come back to it
    task automatic waitForHalt();
        @(negedge Clk);
        while (CurrentState == DekatronPkg::StHalt) @(negedge Clk);
        while (CurrentState != DekatronPkg::StHalt) @(negedge Clk);
    endtask

    task automatic makeStraightProgram(input int len);
        int r;
        for (int i = 0; i < len - 1; i++) begin
            r = $unsigned($random(seed)) % 8;
            case (r)
                0:       progMem[i] = OpNop;
                1:       progMem[i] = OpDataInc;
                2:       progMem[i] = OpDataDec;
                3:       progMem[i] = OpApInc;
                4:       progMem[i] = OpApDec;
                5:       progMem[i] = OpCout;
                6:       progMem[i] = 4'd7;  // Unused code runs as NOP
                default: progMem[i] = OpDataInc;
            endcase
        end
        progMem[len - 1] = OpHalt;
    endtask

    // n increments, then  [ - > > + + [ - < + > ] < < ]  [ > [ + ] . ]  . > . > . halt
    task automatic makeLoopProgram(input int n);
        logic [111:0] body;
        body = 112'hA344_22A3_524B_55BA_4A2B_8B84_8481;
        for (int i = 0; i < 9; i++) begin
            progMem[i] = (i < n) ? OpDataInc : OpNop;
        end
        for (int k = 0; k < 28; k++) begin
            progMem[9 + k] = body[(27 - k) * 4 +: 4];
        end
    endtask

    // Interprets progMem from a cleared machine until HALT
    task automatic runModel();
        int         steps;
        int         depth;
        logic [3:0] op;
        for (int i = 0; i < 10; i++) begin
            mCells[i] = 0;
        end
        mAp   = 0;
        mIp   = 0;
        steps = 0;
        coutExp.delete();
        traceIp.delete();
        traceAp.delete();
        while (steps < 5000) begin
            while (progMem[mIp] == OpLoopOpen || progMem[mIp] == OpLoopClose) begin
                depth = 1;
                if (progMem[mIp] == OpLoopOpen && mCells[mAp] == 0) begin
                    while (depth != 0) begin
                        mIp = (mIp + 1) % 100;
                        if (progMem[mIp] == OpLoopOpen) depth++;
                        else if (progMem[mIp] == OpLoopClose) depth--;
                    end
                end else if (progMem[mIp] == OpLoopClose && mCells[mAp] != 0) begin
                    while (depth != 0) begin
                        mIp = (mIp + 99) % 100;
                        if (progMem[mIp] == OpLoopClose) depth++;
                        else if (progMem[mIp] == OpLoopOpen) depth--;
                    end
                end
                mIp = (mIp + 1) % 100;  // Continue after the bracket
            end
            op  = progMem[mIp];
            mIp = (mIp + 1) % 100;
            case (op)
                OpDataInc: mCells[mAp] = (mCells[mAp] + 1) % 1000;
                OpDataDec: mCells[mAp] = (mCells[mAp] + 999) % 1000;
                OpApInc:   mAp = (mAp + 1) % 10;
                OpApDec:   mAp = (mAp + 9) % 10;
                OpCout:    coutExp.push_back(mCells[mAp]);
                default: ;
            endcase
            traceIp.push_back(mIp);
            traceAp.push_back(mAp);
            steps++;
            if (op == OpHalt) break;
        end
    endtask

    always @(negedge Clk) begin : coutMonitor
        int expVal;
        if (coutArmed && CoutValid) begin
            coutSeen++;
            assert (coutExp.size() > 0) else begin
                $display("Error: CoutValid pulsed with no character left in the model");
                coutErrors++;
            end
            if (coutExp.size() > 0) begin
                expVal = coutExp.pop_front();
                assert (32'(Data) == toBcd(expVal)) else begin
                    $display("[FAIL] Data at CoutValid: got 0x%0h expected 0x%0h",
                             Data, toBcd(expVal));
                    coutErrors++;
                end
            end
        end
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < TimeoutLimit) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout: run still going after %0d cycles", cycleCount);
        $display("Test failures found");
        $finish;
    end

    initial begin
        Rst_n      = 1'b0;
        Halt       = 1'b0;
        Step       = 1'b0;
        Run        = 1'b0;
        ProgWe     = 1'b0;
        ProgAddr   = '0;
        ProgData   = '0;
        seed       = 32'h80abaf0f;
        coutArmed  = 1'b0;
        coutSeen   = 0;
        coutErrors = 0;
        testErrors = 0;
        testNum    = 1;
        passCount  = 0;
        failCount  = 0;
        for (int i = 0; i < 100; i++) begin
            progMem[i] = OpNop;
        end

        applyReset();
        makeStraightProgram(StraightLen);
        loadProgram(StraightLen);
        runModel();
        coutTotal = coutExp.size();
        coutArmed = 1'b1;
        pulseRun();
        waitForHalt();
        coutArmed = 1'b0;
        checkValue("IpAddress", 32'(IpAddress), toBcd(mIp));
        checkValue("IpAddress after HALT", 32'(IpAddress), toBcd(StraightLen));
        checkValue("ApAddress", 32'(ApAddress), toBcd(mAp));
        checkValue("Data", 32'(Data), toBcd(mCells[mAp]));
        finishTest("straight-line run");

        testErrors = coutErrors;
        checkValue("CoutValid count", coutSeen, coutTotal);
        finishTest("character out");

        applyReset();
        loadProgram(StraightLen);
        runModel();
        for (int s = 0; s < traceIp.size(); s++) begin
            pulseStep();
            waitForHalt();
            checkValue("IpAddress after step", 32'(IpAddress), toBcd(traceIp[s]));
            checkValue("ApAddress after step", 32'(ApAddress), toBcd(traceAp[s]));
        end
        finishTest("single step");

        applyReset();
        loopN = 1 + ($unsigned($random(seed)) % 9);
        makeLoopProgram(loopN);
        loadProgram(LoopLen);
        runModel();
        coutTotal  = coutExp.size();
        coutSeen   = 0;
        coutErrors = 0;
        coutArmed  = 1'b1;
        pulseRun();
        waitForHalt();
        coutArmed  = 1'b0;
        testErrors = coutErrors;
        checkValue("CoutValid count", coutSeen, coutTotal);  // Cells 0 to 2 shown at the end
        checkValue("IpAddress", 32'(IpAddress), toBcd(mIp));
        checkValue("ApAddress", 32'(ApAddress), toBcd(mAp));
        checkValue("Data", 32'(Data), toBcd(mCells[mAp]));
        checkValue("LoopCount", 32'(LoopCount), 0);
        finishTest("loops");

        applyReset();
        makeStraightProgram(LongLen);
        loadProgram(LongLen);
        runModel();
        haltDelay = 50 + ($unsigned($random(seed)) % 800);
        pulseRun();
        repeat (haltDelay) @(posedge Clk);
        Halt <= 1'b1;
        @(negedge Clk);
        while (CurrentState != DekatronPkg::StHalt) @(negedge Clk);
        confirm(32'(IpAddress) != toBcd(mIp), "machine ran to the end before Halt took effect");
        @(posedge Clk);
        Halt <= 1'b0;
        pulseRun();
        waitForHalt();
        checkValue("IpAddress", 32'(IpAddress), toBcd(mIp));
        checkValue("ApAddress", 32'(ApAddress), toBcd(mAp));
        checkValue("Data", 32'(Data), toBcd(mCells[mAp]));
        finishTest("halt and resume");

        applyReset();
        makeStraightProgram(LongLen);
        loadProgram(LongLen);
        resetDelay = 100 + ($unsigned($random(seed)) % 400);
        pulseRun();
        repeat (resetDelay) @(posedge Clk);
        applyReset();
        @(negedge Clk);
        checkValue("CurrentState", 32'(CurrentState), 32'(DekatronPkg::StHalt));
        checkValue("CoutValid", 32'(CoutValid), 0);
        checkValue("IpAddress", 32'(IpAddress), 0);
        checkValue("ApAddress", 32'(ApAddress), 0);
        checkValue("Data", 32'(Data), 0);
        checkValue("LoopCount", 32'(LoopCount), 0);
        finishTest("reset");

        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
